// ==== divTop.f ====
hdl/divPkg.sv
hdl/divRequestIntake.sv
hdl/divOperandFifo.sv
hdl/divRestoringCore.sv
hdl/divTop.sv
tests/divTopTb.sv

// ==== Bender.yml ====
package:
  name: divTop

sources:
  - hdl/divPkg.sv
  - hdl/divRequestIntake.sv
  - hdl/divOperandFifo.sv
  - hdl/divRestoringCore.sv
  - hdl/divTop.sv
  - target: test
    files:
      - tests/divTopTb.sv

// ==== tests/divTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module divTopTb import divPkg::*; ();

	localparam int NUM_DIRECTED = 8;
	localparam int NUM_RANDOM = 60;
	localparam int HOLD_CYCLES = 40;
	localparam int HOLD_REQUESTS = FIFO_DEPTH + 3; // one more than the subsystem can hold
	localparam int TOTAL_REQUESTS = NUM_DIRECTED + NUM_RANDOM + HOLD_REQUESTS;
	localparam int WATCHDOG_CYCLES = TOTAL_REQUESTS * (DIV_STEPS + 4) * 2;

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	logic [DIV_WIDTH-1:0] inDividend;
	logic [DIV_WIDTH-1:0] inDivisor;
	logic inReady;
	logic outValid;
	logic [DIV_WIDTH-1:0] outQuotient;
	logic [DIV_WIDTH-1:0] outRemainder;
	logic [TAG_WIDTH-1:0] outTag;
	logic outReady;

	integer seed = 32'h54e0;
	int errorCount = 0;
	int acceptCount = 0;
	int resultCount = 0;
	int readyMode = 0; // 0 random, 1 held low, 2 always high
	logic resetPast = 1'b0;

	// dividend, divisor, tag per outstanding request
	logic [2*DIV_WIDTH+TAG_WIDTH-1:0] pending [$];
	logic headValid = 1'b0;
	logic [DIV_WIDTH-1:0] headDividend;
	logic [DIV_WIDTH-1:0] headDivisor;
	logic [TAG_WIDTH-1:0] headTag;
	logic [DIV_WIDTH-1:0] expQuotient;
	logic [DIV_WIDTH-1:0] expRemainder;

	divTop divTop_inst (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inDividend(inDividend), .inDivisor(inDivisor), .inReady(inReady),
		.outValid(outValid), .outQuotient(outQuotient), .outRemainder(outRemainder),
		.outTag(outTag), .outReady(outReady)
	);

	always #4 clk = ~clk;

	assign expQuotient = (headDivisor == '0) ? {DIV_WIDTH{1'b1}} : headDividend / headDivisor;
	assign expRemainder = (headDivisor == '0) ? headDividend : headDividend % headDivisor;

	task automatic noteFailure(input string msg);
		errorCount++;
		$display("FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic sendRequest(input logic [DIV_WIDTH-1:0] dividend,
		input logic [DIV_WIDTH-1:0] divisor);
		int gap;
		gap = $random(seed) & 3; // idle cycles before the request
		repeat (gap) @(negedge clk);
		inValid = 1'b1;
		inDividend = dividend;
		inDivisor = divisor;
		@(posedge clk);
		while (!inReady)
			@(posedge clk);
		@(negedge clk);
		inValid = 1'b0;
	endtask

	always @(negedge clk)
	begin
		case (readyMode)
			0: outReady = $random(seed) & 1;
			1: outReady = 1'b0;
			default: outReady = 1'b1;
		endcase
	end

	// reference model
	always @(posedge clk)
	begin
		resetPast <= !rst;
		if (rst && outValid && outReady && pending.size() != 0)
		begin
			pending.delete(0);
			resultCount++;
		end
		if (rst && inValid && inReady)
		begin
			pending.push_back({inDividend, inDivisor, TAG_WIDTH'(acceptCount)});
			acceptCount++;
		end
		if (pending.size() != 0)
		begin
			headValid <= 1'b1;
			{headDividend, headDivisor, headTag} <= pending[0];
		end
		else
			headValid <= 1'b0;
	end

	resultExpected: assert property (@(posedge clk) disable iff (!rst)
		outValid && outReady |-> headValid)
		else noteFailure("result came out with no outstanding request");

	resultValue: assert property (@(posedge clk) disable iff (!rst)
		outValid && outReady && headValid |->
			outQuotient == expQuotient && outRemainder == expRemainder)
		else noteFailure("quotient or remainder differs from the reference model");

	divIdentity: assert property (@(posedge clk) disable iff (!rst)
		outValid && outReady && headValid && headDivisor != '0 |->
			32'(outQuotient) * 32'(headDivisor) + 32'(outRemainder) == 32'(headDividend)
			&& outRemainder < headDivisor)
		else noteFailure("quotient times divisor plus remainder is not the dividend");

	zeroDivisor: assert property (@(posedge clk) disable iff (!rst)
		outValid && outReady && headValid && headDivisor == '0 |->
			outQuotient == {DIV_WIDTH{1'b1}} && outRemainder == headDividend)
		else noteFailure("divide-by-zero result is not all ones with the dividend");

	tagOrder: assert property (@(posedge clk) disable iff (!rst)
		outValid && outReady && headValid |-> outTag == headTag)
		else noteFailure("result tag out of order");

	holdOutput: assert property (@(posedge clk) disable iff (!rst)
		outValid && !outReady |=> outValid && $stable(outQuotient)
			&& $stable(outRemainder) && $stable(outTag))
		else noteFailure("result dropped or changed while outReady was low");

	resetState: assert property (@(posedge clk)
		resetPast |-> !outValid && inReady)
		else noteFailure("outValid high or inReady low around reset");

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		int i;
		int holdAccepted;
		logic took;
		logic [31:0] r;
		logic [DIV_WIDTH-1:0] divisor;
		rst = 1'b0;
		inValid = 1'b0;
		inDividend = '0;
		inDivisor = '0;
		outReady = 1'b0;
		repeat (16) @(negedge clk);
		rst = 1'b1;

		sendRequest(16'h1234, 16'h0000); // zero divisors
		sendRequest(16'hffff, 16'h0000);
		sendRequest(16'h0000, 16'h0000);
		sendRequest(16'habcd, 16'h0001);
		sendRequest(16'hffff, 16'h0001);
		sendRequest(16'h0005, 16'h0009); // dividend below divisor
		sendRequest(16'h00ff, 16'hff00);
		sendRequest(16'hffff, 16'hffff);

		// drain, then stall the output
		readyMode = 2;
		while (pending.size() != 0)
			@(negedge clk);
		readyMode = 1;
		@(negedge clk);
		holdAccepted = 0;
		r = $random(seed);
		inValid = 1'b1;
		inDividend = r[31:16];
		inDivisor = r[15:0];
		for (i = 0; i < HOLD_CYCLES; i++)
		begin
			@(posedge clk);
			took = inReady;
			@(negedge clk);
			if (took)
			begin
				holdAccepted++;
				r = $random(seed);
				inDividend = r[31:16];
				inDivisor = r[15:0];
			end
		end
		assert (holdAccepted == FIFO_DEPTH + 2 && !inReady)
			else noteFailure("intake did not stop after FIFO_DEPTH + 2 requests");
		readyMode = 2;
		@(posedge clk);
		while (!inReady)
			@(posedge clk);
		@(negedge clk);
		inValid = 1'b0;

		readyMode = 0;
		for (i = 0; i < NUM_RANDOM; i++)
		begin
			r = $random(seed);
			case (r[17:16])
				2'd0: divisor = r[31:16];
				2'd1: divisor = {8'h00, r[23:16]};
				2'd2: divisor = {12'h000, r[19:16]}; // sometimes zero
				default: divisor = r[15:0] >> r[19:16];
			endcase
			sendRequest(r[15:0], divisor);
		end

		readyMode = 2;
		while (pending.size() != 0)
			@(negedge clk);
		repeat (4) @(negedge clk);
		assert (acceptCount == TOTAL_REQUESTS && resultCount == TOTAL_REQUESTS)
			else noteFailure("not every request was accepted and answered");

		$display("%0d errors, %0d requests accepted, %0d results checked",
			errorCount, acceptCount, resultCount);
		if (errorCount == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/divTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module divTop import divPkg::*;
(
	input wire clk,
	input wire rst,
	input wire inValid,
	input wire [DIV_WIDTH-1:0] inDividend,
	input wire [DIV_WIDTH-1:0] inDivisor,
	output logic inReady,
	output logic outValid,
	output logic [DIV_WIDTH-1:0] outQuotient,
	output logic [DIV_WIDTH-1:0] outRemainder,
	output logic [TAG_WIDTH-1:0] outTag,
	input wire outReady
);

	// intake to FIFO
	logic reqValid;
	logic reqReady;
	logic [DIV_WIDTH-1:0] reqDividend;
	logic [DIV_WIDTH-1:0] reqDivisor;
	logic [TAG_WIDTH-1:0] reqTag;
	logic reqDivZero;

	// FIFO to core
	logic opValid;
	logic opReady;
	logic [DIV_WIDTH-1:0] opDividend;
	logic [DIV_WIDTH-1:0] opDivisor;
	logic [TAG_WIDTH-1:0] opTag;
	logic opDivZero;

	divRequestIntake divRequestIntake_inst (
		.clk(clk), .rst(rst),
		.inValid(inValid), .inDividend(inDividend), .inDivisor(inDivisor), .inReady(inReady),
		.reqValid(reqValid), .reqDividend(reqDividend), .reqDivisor(reqDivisor),
		.reqTag(reqTag), .reqDivZero(reqDivZero), .reqReady(reqReady)
	);

	divOperandFifo divOperandFifo_inst (
		.clk(clk), .rst(rst),
		.reqValid(reqValid), .reqDividend(reqDividend), .reqDivisor(reqDivisor),
		.reqTag(reqTag), .reqDivZero(reqDivZero), .reqReady(reqReady),
		.opValid(opValid), .opDividend(opDividend), .opDivisor(opDivisor),
		.opTag(opTag), .opDivZero(opDivZero), .opReady(opReady)
	);

	divRestoringCore divRestoringCore_inst (
		.clk(clk), .rst(rst),
		.opValid(opValid), .opDividend(opDividend), .opDivisor(opDivisor),
		.opTag(opTag), .opDivZero(opDivZero), .opReady(opReady),
		.outValid(outValid), .outQuotient(outQuotient), .outRemainder(outRemainder),
		.outTag(outTag), .outReady(outReady)
	);

endmodule

`default_nettype wire

// ==== hdl/divRestoringCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module divRestoringCore import divPkg::*;
(
	input wire clk,
	input wire rst,
	input wire opValid,
	input wire [DIV_WIDTH-1:0] opDividend,
	input wire [DIV_WIDTH-1:0] opDivisor,
	input wire [TAG_WIDTH-1:0] opTag,
	input wire opDivZero,
	output logic opReady,
	output logic outValid,
	output logic [DIV_WIDTH-1:0] outQuotient,
	output logic [DIV_WIDTH-1:0] outRemainder,
	output logic [TAG_WIDTH-1:0] outTag,
	input wire outReady
);

	logic [1:0] state;
	logic [$clog2(DIV_STEPS+1)-1:0] stepCount; // can represent DIV_STEPS itself
	divShiftWord_t work;
	divShiftWord_t shifted;
	divShiftWord_t stepWord;
	logic [DIV_WIDTH-1:0] divisorReg;
	logic [DIV_WIDTH:0] trial;
	logic take;
	logic lastStep;

	assign opReady = (state == CORE_IDLE); // idle means the result register is free
	assign outValid = (state == CORE_RESULT);
	assign take = opValid && opReady;
	assign lastStep = (stepCount == $bits(stepCount)'(DIV_STEPS - 1));

	// one restoring step
	always_comb
	begin
		shifted.raw = work.raw << 1;
		// the remainder MSB shifted out is the 17th bit of the trial value
		trial = {work.half.rem[DIV_WIDTH-1], shifted.half.rem} - {1'b0, divisorReg};
		stepWord = shifted;
		if (!trial[DIV_WIDTH]) // no borrow
		begin
			stepWord.half.rem = trial[DIV_WIDTH-1:0];
			stepWord.half.quo[0] = 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= CORE_IDLE;
			stepCount <= '0;
		end
		else
		begin
			case (state)
				CORE_IDLE:
				begin
					if (take)
					begin
						stepCount <= '0;
						state <= opDivZero ? CORE_RESULT : CORE_ITER; // zero divisor skips iterations
					end
				end
				CORE_ITER:
				begin
					if (lastStep)
						state <= CORE_RESULT;
					else
						stepCount <= stepCount + 1'b1;
				end
				CORE_RESULT:
				begin
					if (outReady)
						state <= CORE_IDLE;
				end
				default:
				begin
					state <= CORE_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			work.raw <= {{DIV_WIDTH{1'b0}}, opDividend};
			divisorReg <= opDivisor;
			outTag <= opTag;
			if (opDivZero)
			begin
				outQuotient <= '1; // fixed divide-by-zero result
				outRemainder <= opDividend;
			end
		end
		else if (state == CORE_ITER)
		begin
			work <= stepWord;
			if (lastStep)
			begin
				outQuotient <= stepWord.half.quo;
				outRemainder <= stepWord.half.rem;
			end
		end
	end

	holdResult: assert property (@(posedge clk) disable iff (!rst)
		outValid && !outReady |=> outValid && $stable(outQuotient)
			&& $stable(outRemainder) && $stable(outTag))
		else $error("result changed under back-pressure");

	stepBound: assert property (@(posedge clk) disable iff (!rst)
		(state == CORE_ITER) |-> stepCount < DIV_STEPS)
		else $error("step counter past DIV_STEPS");

	divLatency: assert property (@(posedge clk) disable iff (!rst)
		take && !opDivZero |-> ##(DIV_STEPS + 1) $rose(outValid))
		else $error("result not ready after DIV_STEPS + 1 cycles");

endmodule

`default_nettype wire

// ==== hdl/divOperandFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module divOperandFifo import divPkg::*;
(
	input wire clk,
	input wire rst,
	input wire reqValid,
	input wire [DIV_WIDTH-1:0] reqDividend,
	input wire [DIV_WIDTH-1:0] reqDivisor,
	input wire [TAG_WIDTH-1:0] reqTag,
	input wire reqDivZero,
	output logic reqReady,
	output logic opValid,
	output logic [DIV_WIDTH-1:0] opDividend,
	output logic [DIV_WIDTH-1:0] opDivisor,
	output logic [TAG_WIDTH-1:0] opTag,
	output logic opDivZero,
	input wire opReady
);

	logic [ENTRY_WIDTH-1:0] mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0] wrPtr;
	logic [FIFO_PTR_WIDTH-1:0] rdPtr;
	logic [FIFO_PTR_WIDTH:0] count; // one extra bit to tell full from empty
	logic wrEn;
	logic rdEn;
	logic full;

	assign full = (count == (FIFO_PTR_WIDTH+1)'(FIFO_DEPTH));
	assign reqReady = !full;
	assign opValid = (count != '0);
	assign wrEn = reqValid && reqReady;
	assign rdEn = opValid && opReady;

	assign {opDividend, opDivisor, opTag, opDivZero} = mem[rdPtr]; // head entry

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			if (wrEn && !rdEn)
				count <= count + 1'b1;
			else if (rdEn && !wrEn)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= {reqDividend, reqDivisor, reqTag, reqDivZero};
	end

	noOverflow: assert property (@(posedge clk) disable iff (!rst)
		full |=> $stable(wrPtr) && count <= FIFO_DEPTH)
		else $error("write into full FIFO");

	noUnderflow: assert property (@(posedge clk) disable iff (!rst)
		!opValid |=> $stable(rdPtr))
		else $error("read from empty FIFO");

endmodule

`default_nettype wire

// ==== hdl/divRequestIntake.sv ====
`timescale 1ns/1ps
`default_nettype none

module divRequestIntake import divPkg::*;
(
	input wire clk,
	input wire rst,
	input wire inValid,
	input wire [DIV_WIDTH-1:0] inDividend,
	input wire [DIV_WIDTH-1:0] inDivisor,
	output logic inReady,
	output logic reqValid,
	output logic [DIV_WIDTH-1:0] reqDividend,
	output logic [DIV_WIDTH-1:0] reqDivisor,
	output logic [TAG_WIDTH-1:0] reqTag,
	output logic reqDivZero,
	input wire reqReady
);

	logic [TAG_WIDTH-1:0] tagCount;
	logic accept;

	assign inReady = !reqValid || reqReady; // empty, or draining this cycle
	assign accept = inValid && inReady;

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			reqValid <= 1'b0;
			tagCount <= '0;
		end
		else
		begin
			if (accept)
			begin
				reqValid <= 1'b1;
				tagCount <= tagCount + 1'b1; // wraps
			end
			else if (reqReady)
			begin
				reqValid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			reqDividend <= inDividend;
			reqDivisor <= inDivisor;
			reqTag <= tagCount;
			reqDivZero <= (inDivisor == '0); // only zero test in the design
		end
	end

	holdReq: assert property (@(posedge clk) disable iff (!rst)
		reqValid && !reqReady |=> reqValid && $stable(reqTag))
		else $error("intake dropped or changed a stalled request");

endmodule

`default_nettype wire

// ==== hdl/divPkg.sv ====
`default_nettype none

package divPkg;

	localparam int DIV_WIDTH = 16; // operand and result width
	localparam int DIV_STEPS = DIV_WIDTH; // one quotient bit per step
	localparam int TAG_WIDTH = 4;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_WIDTH = 2; // log2 of FIFO_DEPTH

	// dividend, divisor, tag and zero-divisor flag
	localparam int ENTRY_WIDTH = 2 * DIV_WIDTH + TAG_WIDTH + 1;

	localparam logic [1:0] CORE_IDLE = 2'b00; // waiting for an operand
	localparam logic [1:0] CORE_ITER = 2'b01; // restoring steps
	localparam logic [1:0] CORE_RESULT = 2'b10; // result offered downstream

	typedef struct packed
	{
		logic [DIV_WIDTH-1:0] rem; // partial remainder, upper half
		logic [DIV_WIDTH-1:0] quo; // dividend bits shifting out, quotient bits shifting in
	} divShiftHalves_t;

	// shifted as one word, read back as remainder and quotient
	typedef union packed
	{
		logic [2*DIV_WIDTH-1:0] raw;
		divShiftHalves_t half;
	} divShiftWord_t;

endpackage

`default_nettype wire
